//--- mix_cfg_pkg.sv
// Mixing configuration types, imported by the input stage and by each channel pipeline
`default_nettype none

package mix_cfg_pkg;

	//////////////////////////////
	// Cross-mix
	//////////////////////////////

	// Strength of the blend with the opposite channel
	typedef enum logic [1:0] {
		MIX_NONE   = 2'd0,
		MIX_LIGHT  = 2'd1,
		MIX_MEDIUM = 2'd2,
		MIX_FULL   = 2'd3
	} mix_mode_t;

	//////////////////////////////
	// Volume
	//////////////////////////////

	// Mute flag on top, right shift count below
	typedef struct packed {
		logic       mute;
		logic [3:0] shift;
	} att_t;

	// Sampled once per accepted frame and carried along with it
	typedef struct packed {
		logic      core_signed;
		mix_mode_t mode;
		att_t      att;
	} mix_cfg_t;

endpackage

`default_nettype wire

//--- mix_data_pkg.sv
// Sample and frame types for the audio path, imported by every stage of the mixer
`default_nettype none

package mix_data_pkg;

	// Cross-mix arithmetic assumes 16-bit samples
	localparam int SAMPLE_W = 16;

	// Final signed sample
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// One bit of headroom for the core plus Linux sum
	typedef logic signed [SAMPLE_W:0] wide_t;

	// Left and right of one frame
	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	//////////////////////////////
	// Input stage to channel
	//////////////////////////////

	// Own sum, halved sum of the other side, and the frame's settings
	typedef struct packed {
		wide_t                 sum;
		sample_t               partner;
		mix_cfg_pkg::mix_cfg_t cfg;
	} chan_in_t;

endpackage

`default_nettype wire

//--- mix_stream_if.sv
// Valid/ready stream that links the mixer stages, with the payload type chosen per instance
`timescale 1ns/1ps
`default_nettype none

interface mix_stream_if #(
	parameter type payload_t = mix_data_pkg::sample_t
) ();

	logic     valid;
	logic     ready;
	payload_t payload;

	// Sending side holds valid and payload until ready
	modport producer (
		output valid,
		output payload,
		input  ready
	);

	// Receiving side
	modport consumer (
		input  valid,
		input  payload,
		output ready
	);

endinterface

`default_nettype wire

//--- mix_input_stage.sv
// Front stage of the mixer that converts and sums one frame and hands a copy to each channel
`timescale 1ns/1ps
`default_nettype none

module mix_input_stage (
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  logic                  i_in_valid,
	output logic                  o_in_ready,
	input  mix_data_pkg::stereo_t i_core,
	input  mix_data_pkg::stereo_t i_linux,
	input  mix_cfg_pkg::mix_cfg_t i_cfg,
	mix_stream_if.producer        ch_left,
	mix_stream_if.producer        ch_right
);
	import mix_data_pkg::*;

	wide_t    sum_l;
	wide_t    sum_r;
	chan_in_t left_d;
	chan_in_t right_d;
	logic     pend_l;
	logic     pend_r;
	logic     accept;

	// Unsigned core audio is halved into the positive range
	function automatic wide_t convert_core(input sample_t s, input logic is_signed);
		if (is_signed)
			return {s[SAMPLE_W-1], s};
		return {2'b00, s[SAMPLE_W-1:1]};
	endfunction

	//////////////////////////////
	// Conversion and sum
	//////////////////////////////

	always_comb begin
		sum_l = convert_core(i_core.left, i_cfg.core_signed)
			+ {i_linux.left[SAMPLE_W-1], i_linux.left};
		sum_r = convert_core(i_core.right, i_cfg.core_signed)
			+ {i_linux.right[SAMPLE_W-1], i_linux.right};

		// Partner is the other side's sum without its lowest bit
		left_d.sum      = sum_l;
		left_d.partner  = sum_r[SAMPLE_W:1];
		left_d.cfg      = i_cfg;
		right_d.sum     = sum_r;
		right_d.partner = sum_l[SAMPLE_W:1];
		right_d.cfg     = i_cfg;
	end

	//////////////////////////////
	// Handshake
	//////////////////////////////

	// Free once each copy is gone or leaves this cycle
	assign o_in_ready = (!pend_l || ch_left.ready) && (!pend_r || ch_right.ready);
	assign accept     = i_in_valid && o_in_ready;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			pend_l <= 1'b0;
			pend_r <= 1'b0;
		end else begin
			pend_l <= accept || (pend_l && !ch_left.ready);
			pend_r <= accept || (pend_r && !ch_right.ready);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			ch_left.payload  <= left_d;
			ch_right.payload <= right_d;
		end
	end

	assign ch_left.valid  = pend_l;
	assign ch_right.valid = pend_r;

endmodule

`default_nettype wire

//--- mix_channel.sv
// Per-channel pipeline of cross-mix, attenuation and clamp, instantiated once per side
`timescale 1ns/1ps
`default_nettype none

module mix_channel (
	input  logic           clk_sys,
	input  logic           resetd,
	mix_stream_if.consumer s_in,
	mix_stream_if.producer m_out
);
	import mix_cfg_pkg::*;
	import mix_data_pkg::*;

	chan_in_t in_w;
	wide_t    part_w;
	wide_t    mix_d;
	wide_t    mix_q;
	att_t     att_q;
	wide_t    att_d;
	wide_t    att_out_q;
	sample_t  clamp_d;
	logic     v_mix;
	logic     v_att;
	logic     v_clamp;
	logic     advance;

	assign in_w   = s_in.payload;
	assign part_w = {in_w.partner[SAMPLE_W-1], in_w.partner};

	// Whole pipeline moves together, stalls only when the last stage is stuck
	assign advance    = !v_clamp || m_out.ready;
	assign s_in.ready = advance;

	//////////////////////////////
	// Mix stage
	//////////////////////////////

	// Shifts are arithmetic, results wrap at 17 bits
	always_comb begin
		case (in_w.cfg.mode)
			MIX_LIGHT:  mix_d = in_w.sum - (in_w.sum >>> 3) + (part_w >>> 2);
			MIX_MEDIUM: mix_d = in_w.sum - (in_w.sum >>> 2) + (part_w >>> 1);
			MIX_FULL:   mix_d = (in_w.sum >>> 1) + part_w;
			default:    mix_d = in_w.sum;
		endcase
	end

	//////////////////////////////
	// Attenuation stage
	//////////////////////////////

	always_comb begin
		if (att_q.mute)
			att_d = '0;
		else
			att_d = mix_q >>> att_q.shift;
	end

	//////////////////////////////
	// Clamp stage
	//////////////////////////////

	// Top two bits disagree on overflow
	assign clamp_d = (att_out_q[SAMPLE_W] ^ att_out_q[SAMPLE_W-1]) ?
		{att_out_q[SAMPLE_W], {(SAMPLE_W-1){~att_out_q[SAMPLE_W]}}} :
		att_out_q[SAMPLE_W-1:0];

	// Valid bits per stage
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			v_mix   <= 1'b0;
			v_att   <= 1'b0;
			v_clamp <= 1'b0;
		end else if (advance) begin
			v_mix   <= s_in.valid;
			v_att   <= v_mix;
			v_clamp <= v_att;
		end
	end

	// Data follows the valid bits
	always_ff @(posedge clk_sys) begin
		if (advance) begin
			mix_q         <= mix_d;
			att_q         <= in_w.cfg.att;
			att_out_q     <= att_d;
			m_out.payload <= clamp_d;
		end
	end

	assign m_out.valid = v_clamp;

endmodule

`default_nettype wire

//--- mix_output_stage.sv
// Back stage of the mixer that pairs the two channel samples into one held output frame
`timescale 1ns/1ps
`default_nettype none

module mix_output_stage (
	input  logic                  clk_sys,
	input  logic                  resetd,
	mix_stream_if.consumer        ch_left,
	mix_stream_if.consumer        ch_right,
	output logic                  o_out_valid,
	input  logic                  i_out_ready,
	output mix_data_pkg::stereo_t o_out
);
	import mix_data_pkg::*;

	stereo_t frame_d;
	logic    take;

	// Only a complete pair moves, and only into a free or draining register
	assign take = ch_left.valid && ch_right.valid && (!o_out_valid || i_out_ready);

	assign ch_left.ready  = take;
	assign ch_right.ready = take;

	assign frame_d = '{left: ch_left.payload, right: ch_right.payload};

	always_ff @(posedge clk_sys) begin
		if (resetd)
			o_out_valid <= 1'b0;
		else if (take)
			o_out_valid <= 1'b1;
		else if (i_out_ready)
			o_out_valid <= 1'b0;
	end

	// Frame holds until the sink takes it
	always_ff @(posedge clk_sys) begin
		if (take)
			o_out <= frame_d;
	end

endmodule

`default_nettype wire

//--- stereo_audio_mixer.sv
// Top level of the stereo mixer with plain ports, wiring input stage, two channels and output
`timescale 1ns/1ps
`default_nettype none

module stereo_audio_mixer (
	input  logic                              clk_sys,
	input  logic                              resetd,

	// Input frame
	input  logic                              i_in_valid,
	output logic                              o_in_ready,
	input  logic [mix_data_pkg::SAMPLE_W-1:0] i_core_l,
	input  logic [mix_data_pkg::SAMPLE_W-1:0] i_core_r,
	input  logic [mix_data_pkg::SAMPLE_W-1:0] i_linux_l,
	input  logic [mix_data_pkg::SAMPLE_W-1:0] i_linux_r,

	// Configuration, sampled with each accepted frame
	input  logic                              i_core_signed,
	input  logic [1:0]                        i_mix_mode,
	input  logic [4:0]                        i_att,

	// Output frame
	output logic                              o_out_valid,
	input  logic                              i_out_ready,
	output logic [mix_data_pkg::SAMPLE_W-1:0] o_out_l,
	output logic [mix_data_pkg::SAMPLE_W-1:0] o_out_r
);
	import mix_cfg_pkg::*;
	import mix_data_pkg::*;

	// Left and right
	localparam int NUM_CHAN = 2;

	stereo_t  core_w;
	stereo_t  linux_w;
	stereo_t  out_w;
	mix_cfg_t cfg_w;

	//////////////////////////////
	// Port packing
	//////////////////////////////

	assign core_w  = '{left: i_core_l, right: i_core_r};
	assign linux_w = '{left: i_linux_l, right: i_linux_r};
	assign cfg_w   = '{
		core_signed: i_core_signed,
		mode:        mix_mode_t'(i_mix_mode),
		att:         att_t'(i_att)
	};

	assign o_out_l = out_w.left;
	assign o_out_r = out_w.right;

	//////////////////////////////
	// Stages
	//////////////////////////////

	mix_stream_if #(.payload_t(chan_in_t)) ch_in  [NUM_CHAN] ();
	mix_stream_if #(.payload_t(sample_t))  ch_out [NUM_CHAN] ();

	mix_input_stage u_input (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_in_valid (i_in_valid),
		.o_in_ready (o_in_ready),
		.i_core     (core_w),
		.i_linux    (linux_w),
		.i_cfg      (cfg_w),
		.ch_left    (ch_in[0]),
		.ch_right   (ch_in[1])
	);

	// Index 0 is left, 1 is right
	for (genvar g = 0; g < NUM_CHAN; g++) begin : g_chan
		mix_channel u_chan (
			.clk_sys (clk_sys),
			.resetd  (resetd),
			.s_in    (ch_in[g]),
			.m_out   (ch_out[g])
		);
	end

	mix_output_stage u_output (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.ch_left     (ch_out[0]),
		.ch_right    (ch_out[1]),
		.o_out_valid (o_out_valid),
		.i_out_ready (i_out_ready),
		.o_out       (out_w)
	);

endmodule

`default_nettype wire

//--- tb_stereo_audio_mixer.sv
// Self-checking testbench for the stereo mixer, compiled from tb.f with this module as top
`timescale 1ns/1ps
`default_nettype none

module tb_stereo_audio_mixer;
	import mix_cfg_pkg::*;
	import mix_data_pkg::*;

	// Cycles that any single wait may take
	localparam int LIMIT = 300;

	logic        clk_sys = 1'b0;
	logic        resetd;
	logic        i_in_valid;
	logic        o_in_ready;
	logic [15:0] i_core_l;
	logic [15:0] i_core_r;
	logic [15:0] i_linux_l;
	logic [15:0] i_linux_r;
	logic        i_core_signed;
	logic [1:0]  i_mix_mode;
	logic [4:0]  i_att;
	logic        o_out_valid;
	logic        i_out_ready;
	logic [15:0] o_out_l;
	logic [15:0] o_out_r;

	int          seed = 44341;
	int          cycle = 0;
	int          err_value = 0;
	int          err_proto = 0;
	int          err_timeout = 0;
	int          start;
	logic [31:0] rnd;
	logic        rand_ready = 1'b0;
	logic        check_lat = 1'b0;
	string       test_name = "reset";
	stereo_t     exp_q[$];
	int          stamp_q[$];
	string       name_q[$];

	stereo_audio_mixer i_dut (.*);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys)
		cycle <= cycle + 1;

	// Sink ready goes random while back-pressure is exercised
	always @(posedge clk_sys) begin
		#1;
		i_out_ready = rand_ready ? $random(seed) : 1'b1;
	end

	// Low 17 bits as a signed value
	function automatic int wrap17(input int v);
		int w;
		w = v & 'h1ffff;
		if (w > 65535)
			w -= 131072;
		return w;
	endfunction

	// Output frame from the conversion, cross-mix, volume and clamp rules
	function automatic stereo_t expected_frame(input stereo_t core, input stereo_t lin,
		input mix_cfg_t cfg);
		int      sum[2];
		int      own;
		int      other;
		int      res;
		sample_t smp[2];
		sample_t ln[2];
		stereo_t r;
		smp[0] = core.left;
		smp[1] = core.right;
		ln[0]  = lin.left;
		ln[1]  = lin.right;
		for (int i = 0; i < 2; i++) begin
			if (cfg.core_signed)
				own = smp[i];
			else
				own = int'($unsigned(smp[i])) / 2;
			sum[i] = wrap17(own + ln[i]);
		end
		for (int i = 0; i < 2; i++) begin
			// Other side enters at half scale
			other = sum[1-i] >>> 1;
			own   = sum[i];
			case (cfg.mode)
				MIX_LIGHT:  res = own - (own >>> 3) + (other >>> 2);
				MIX_MEDIUM: res = own - (own >>> 2) + (other >>> 1);
				MIX_FULL:   res = (own >>> 1) + other;
				default:    res = own;
			endcase
			res = cfg.att.mute ? 0 : wrap17(res) >>> cfg.att.shift;
			if (res > 32767)
				res = 32767;
			else if (res < -32768)
				res = -32768;
			if (i == 0)
				r.left = res[15:0];
			else
				r.right = res[15:0];
		end
		return r;
	endfunction

	task automatic check_frame(input string name, input stereo_t exp, input stereo_t act);
		if (act !== exp) begin
			err_value++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			err_value++;
			$display("Fail %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_cycles(input string name, input int exp, input int act);
		if (act != exp) begin
			err_value++;
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	//////////////////////////////
	// Scoreboard
	//////////////////////////////

	// Handshakes are settled at the falling edge
	always @(negedge clk_sys) begin
		if (i_in_valid && o_in_ready) begin
			exp_q.push_back(expected_frame({i_core_l, i_core_r}, {i_linux_l, i_linux_r},
				{i_core_signed, i_mix_mode, i_att}));
			stamp_q.push_back(cycle);
			name_q.push_back(test_name);
		end
		if (o_out_valid && i_out_ready) begin
			if (exp_q.size() == 0) begin
				err_proto++;
				$display("An output frame appeared with no accepted frame outstanding");
			end else begin
				if (check_lat)
					check_cycles("latency", 5, cycle - stamp_q[0]);
				stamp_q.delete(0);
				check_frame(name_q.pop_front(), exp_q.pop_front(), {o_out_l, o_out_r});
			end
		end
	end

	// Present one frame and wait until the mixer accepts it
	task automatic send_frame(input stereo_t core, input stereo_t lin, input mix_cfg_t cfg);
		int   tries;
		logic taken;
		tries = 0;
		taken = 1'b0;
		{i_core_l, i_core_r}               = core;
		{i_linux_l, i_linux_r}             = lin;
		{i_core_signed, i_mix_mode, i_att} = cfg;
		i_in_valid = 1'b1;
		while (!taken && tries < LIMIT) begin
			@(negedge clk_sys);
			taken = (o_in_ready === 1'b1);
			@(posedge clk_sys);
			#1;
			tries++;
		end
		if (!taken) begin
			err_timeout++;
			$display("Timeout: the mixer did not accept a frame within %0d cycles", LIMIT);
		end
	endtask

	// Stop sending and wait until every accepted frame has come out
	task automatic wait_drain();
		int tries;
		tries = 0;
		i_in_valid = 1'b0;
		while (exp_q.size() != 0 && tries < LIMIT) begin
			@(posedge clk_sys);
			#1;
			tries++;
		end
		if (exp_q.size() != 0) begin
			err_timeout++;
			$display("Timeout: %0d accepted frames never came out", exp_q.size());
		end
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin
		resetd        = 1'b1;
		i_in_valid    = 1'b0;
		i_core_l      = '0;
		i_core_r      = '0;
		i_linux_l     = '0;
		i_linux_r     = '0;
		i_core_signed = 1'b0;
		i_mix_mode    = '0;
		i_att         = '0;
		i_out_ready   = 1'b1;

		repeat (8) begin
			@(posedge clk_sys);
			#1;
			check_flag("reset out_valid", 1'b0, o_out_valid);
			check_flag("reset in_ready", 1'b1, o_in_ready);
		end
		resetd = 1'b0;

		// First edge with reset released and no frame offered
		@(posedge clk_sys);
		#1;
		check_flag("after reset out_valid", 1'b0, o_out_valid);
		check_flag("after reset in_ready", 1'b1, o_in_ready);

		// Plain sum with an unsigned then a signed core
		for (int s = 0; s < 2; s++) begin
			test_name = s ? "sum signed" : "sum unsigned";
			repeat (20)
				send_frame($random(seed), $random(seed), {s[0], MIX_NONE, 5'd0});
		end

		// Every mode in turn
		test_name = "crossmix";
		for (int m = 0; m < 64; m++) begin
			rnd = $random(seed);
			send_frame($random(seed), $random(seed), {rnd[0], m[1:0], 5'd0});
		end

		test_name = "attenuation";
		repeat (32) begin
			rnd = $random(seed);
			send_frame($random(seed), $random(seed), {rnd[2:0], 1'b0, rnd[7:4]});
		end
		test_name = "mute";
		repeat (8) begin
			rnd = $random(seed);
			send_frame($random(seed), $random(seed), {rnd[2:0], 1'b1, rnd[7:4]});
		end

		// Full-scale inputs drive both rails
		test_name = "saturation";
		send_frame(32'h7fff_7fff, 32'h7fff_7fff, {1'b1, MIX_FULL, 5'd0});
		send_frame(32'h8000_8000, 32'h8000_8000, {1'b1, MIX_FULL, 5'd0});
		send_frame(32'hffff_ffff, 32'h7fff_7fff, {1'b0, MIX_FULL, 5'd0});
		send_frame(32'h7fff_8000, 32'h7fff_8000, {1'b1, MIX_FULL, 5'd0});
		wait_drain();

		test_name  = "backpressure";
		rand_ready = 1'b1;
		repeat (60)
			send_frame($random(seed), $random(seed), $random(seed));
		wait_drain();
		rand_ready = 1'b0;
		@(posedge clk_sys);
		#1;

		// Sink always ready so a frame enters every cycle
		test_name = "latency";
		check_lat = 1'b1;
		start     = cycle;
		repeat (10)
			send_frame($random(seed), $random(seed), $random(seed));
		check_cycles("throughput", 10, cycle - start);
		wait_drain();
		check_lat = 1'b0;

		// Quiet period catches any extra output frame
		repeat (10) @(posedge clk_sys);
		$display("Errors: value %0d, protocol %0d, timeout %0d",
			err_value, err_proto, err_timeout);
		if (err_value + err_proto + err_timeout == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
mix_cfg_pkg.sv
mix_data_pkg.sv
mix_stream_if.sv
mix_input_stage.sv
mix_channel.sv
mix_output_stage.sv
stereo_audio_mixer.sv
tb_stereo_audio_mixer.sv
